//--- source/xbus_defines.svh
// Address windows, SDRAM size and latencies, and bus timeout for the xbus
`ifndef XBUS_DEFINES_SVH
`define XBUS_DEFINES_SVH

// First address past the RAM window
`define XBUS_RAM_LIMIT 22'o11000000

// Backed words; the rest of the RAM window up to the limit is the gap
`define SDRAM_WORDS 4096

// Cycles from command accept to ready or done
`define SDRAM_READ_LAT 3
`define SDRAM_WRITE_LAT 2

// I/O register window
`define XBUS_IO_BASE 22'o17777700
`define XBUS_IO_WORDS 16

// Cycles before an unclaimed request is acked
`define XBUS_TIMEOUT 16

// Returned by the gap and by a timed out read
`define XBUS_DEAD_DATA 32'hffff_ffff

`endif

//--- source/xbus_pkg.sv
// Bus and SDRAM request and response structs
package xbus_pkg;

   // Master request, held until ack
   typedef struct packed {
      logic [21:0] addr;
      logic [31:0] data;
      logic        req;
      logic        write;
   } xbus_req_t;

   // Per-target response
   typedef struct packed {
      logic [31:0] data;
      logic        ack;
      logic        decode;
   } xbus_rsp_t;

   // Command from the RAM bridge to the SDRAM controller
   typedef struct packed {
      logic [21:0] addr;
      logic [31:0] data;
      logic        req;
      logic        write;
   } sdram_cmd_t;

   // Controller answer; ready and done are single-cycle pulses
   typedef struct packed {
      logic [31:0] data;
      logic        ready;
      logic        done;
   } sdram_rsp_t;

endpackage

//--- source/xbus_ctrl.sv
// Bus control with target response select, unmapped request timeout and timeout count
`include "xbus_defines.svh"

module xbus_ctrl (
   input  logic                clk,
   input  logic                reset,
   input  xbus_pkg::xbus_req_t bus_req,
   input  xbus_pkg::xbus_rsp_t ram_rsp,
   input  xbus_pkg::xbus_rsp_t io_rsp,
   output xbus_pkg::xbus_rsp_t bus_rsp,
   output logic [15:0]         timeout_count
);

   localparam int WAIT_W = $clog2(`XBUS_TIMEOUT + 1);

   logic              claimed;
   logic              waiting;
   logic              wait_last;
   logic [WAIT_W-1:0] wait_cnt;
   logic              timeout_ack;

   // Targets decode for themselves; only their flags are seen here
   assign claimed = ram_rsp.decode | io_rsp.decode;
   assign waiting = bus_req.req & ~claimed;

   // Ack lands in cycle XBUS_TIMEOUT counted from the first req cycle
   assign wait_last = (wait_cnt == WAIT_W'(`XBUS_TIMEOUT - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         wait_cnt    <= '0;
         timeout_ack <= 1'b0;
      end else if (!waiting) begin
         wait_cnt    <= '0;
         timeout_ack <= 1'b0;
      end else begin
         // Counter parks at the limit so ack fires once per request
         if (wait_cnt != WAIT_W'(`XBUS_TIMEOUT)) begin
            wait_cnt <= wait_cnt + 1'b1;
         end
         timeout_ack <= wait_last;
      end
   end

   // Saturating count of timed out requests
   always_ff @(posedge clk) begin
      if (reset) begin
         timeout_count <= '0;
      end else if (waiting && wait_last && timeout_count != 16'hffff) begin
         timeout_count <= timeout_count + 1'b1;
      end
   end

   // RAM first, then I/O, else the timeout path
   always_comb begin
      if (ram_rsp.decode) begin
         bus_rsp = ram_rsp;
      end else if (io_rsp.decode) begin
         bus_rsp = io_rsp;
      end else begin
         bus_rsp.data   = `XBUS_DEAD_DATA;
         bus_rsp.ack    = timeout_ack;
         bus_rsp.decode = 1'b0;
      end
   end

endmodule

//--- source/xbus_ram.sv
// RAM bridge between the xbus and the SDRAM controller with the unbacked gap
`include "xbus_defines.svh"

module xbus_ram (
   input  logic                 clk,
   input  logic                 reset,
   input  xbus_pkg::xbus_req_t  bus_req,
   output xbus_pkg::xbus_rsp_t  ram_rsp,
   output xbus_pkg::sdram_cmd_t sdram_cmd,
   input  xbus_pkg::sdram_rsp_t sdram_rsp
);

   logic decode;
   logic backed;
   logic gap;
   logic gap_ack;
   logic gap_served;

   // Whole window decodes, but only the fitted words reach the SDRAM
   assign decode = (bus_req.addr < `XBUS_RAM_LIMIT);
   assign backed = (bus_req.addr < 22'(`SDRAM_WORDS));
   assign gap    = decode & ~backed;

   assign sdram_cmd.addr  = bus_req.addr;
   assign sdram_cmd.data  = bus_req.data;
   assign sdram_cmd.req   = bus_req.req & backed & ~bus_req.write;
   assign sdram_cmd.write = bus_req.req & backed & bus_req.write;

   // One registered gap ack pulse that cannot repeat until req drops
   always_ff @(posedge clk) begin
      if (reset) begin
         gap_ack    <= 1'b0;
         gap_served <= 1'b0;
      end else begin
         gap_ack    <= bus_req.req & gap & ~gap_ack & ~gap_served;
         gap_served <= bus_req.req & (gap_served | gap_ack);
      end
   end

   // Backed accesses finish combinationally on done or ready
   assign ram_rsp.ack = (sdram_cmd.write & sdram_rsp.done) |
                        (sdram_cmd.req & sdram_rsp.ready) |
                        gap_ack;

   assign ram_rsp.data   = gap ? `XBUS_DEAD_DATA : sdram_rsp.data;
   assign ram_rsp.decode = decode;

endmodule

//--- source/sdram_ctrl.sv
// Behavioural single-port SDRAM controller with fixed read and write latency
`include "xbus_defines.svh"

module sdram_ctrl (
   input  logic                 clk,
   input  logic                 reset,
   input  xbus_pkg::sdram_cmd_t sdram_cmd,
   output xbus_pkg::sdram_rsp_t sdram_rsp
);

   localparam int AW    = $clog2(`SDRAM_WORDS);
   localparam int LAT_W = 4;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUSY,
      ST_RECOVER
   } state_t;

   state_t            state;
   logic [LAT_W-1:0]  lat_cnt;
   logic              start;
   logic              finish;
   logic [AW-1:0]     cmd_addr;
   logic [31:0]       cmd_data;
   logic              cmd_write;
   logic [31:0]       rd_data;
   logic              ready_q;
   logic              done_q;
   logic [31:0]       mem [`SDRAM_WORDS];

   // Array starts cleared
   initial begin
      for (int i = 0; i < `SDRAM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   assign start  = (state == ST_IDLE) & (sdram_cmd.req | sdram_cmd.write);
   assign finish = (state == ST_BUSY) & (lat_cnt == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= ST_IDLE;
         lat_cnt <= '0;
         ready_q <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         ready_q <= 1'b0;
         done_q  <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (start) begin
                  state   <= ST_BUSY;
                  lat_cnt <= sdram_cmd.write ? LAT_W'(`SDRAM_WRITE_LAT - 1) :
                                               LAT_W'(`SDRAM_READ_LAT - 1);
               end
            end
            ST_BUSY: begin
               if (finish) begin
                  state   <= ST_RECOVER;
                  ready_q <= ~cmd_write;
                  done_q  <= cmd_write;
               end else begin
                  lat_cnt <= lat_cnt - 1'b1;
               end
            end
            // Held req is ignored here while the master sees its ack
            ST_RECOVER: state <= ST_IDLE;
            default:    state <= ST_IDLE;
         endcase
      end
   end

   // Command latch and array access
   always_ff @(posedge clk) begin
      if (start) begin
         cmd_addr  <= sdram_cmd.addr[AW-1:0];
         cmd_data  <= sdram_cmd.data;
         cmd_write <= sdram_cmd.write;
      end
      if (finish && cmd_write) begin
         mem[cmd_addr] <= cmd_data;
      end
      if (finish && !cmd_write) begin
         rd_data <= mem[cmd_addr];
      end
   end

   assign sdram_rsp.data  = rd_data;
   assign sdram_rsp.ready = ready_q;
   assign sdram_rsp.done  = done_q;

endmodule

//--- source/xbus_io.sv
// I/O register block with scratch register, cycle counter and timeout count
`include "xbus_defines.svh"

module xbus_io (
   input  logic                clk,
   input  logic                reset,
   input  xbus_pkg::xbus_req_t bus_req,
   input  logic [15:0]         timeout_count,
   output xbus_pkg::xbus_rsp_t io_rsp
);

   localparam int IO_AW = $clog2(`XBUS_IO_WORDS);

   localparam logic [IO_AW-1:0] OFS_SCRATCH  = IO_AW'(0);
   localparam logic [IO_AW-1:0] OFS_CYCLES   = IO_AW'(1);
   localparam logic [IO_AW-1:0] OFS_TIMEOUTS = IO_AW'(2);

   logic             decode;
   logic [IO_AW-1:0] offset;
   logic             start;
   logic             ack_q;
   logic             served;
   logic [31:0]      scratch;
   logic [31:0]      cycles;
   logic [31:0]      rd_data;

   assign decode = (bus_req.addr >= `XBUS_IO_BASE) &&
                   (bus_req.addr < `XBUS_IO_BASE + 22'(`XBUS_IO_WORDS));
   assign offset = IO_AW'(bus_req.addr - `XBUS_IO_BASE);

   // One access per request
   assign start = bus_req.req & decode & ~ack_q & ~served;

   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q   <= 1'b0;
         served  <= 1'b0;
         scratch <= '0;
         cycles  <= '0;
      end else begin
         cycles <= cycles + 1'b1;
         ack_q  <= start;
         served <= bus_req.req & (served | ack_q);
         if (start && bus_req.write && offset == OFS_SCRATCH) begin
            scratch <= bus_req.data;
         end
      end
   end

   // Read data captured with the ack
   always_ff @(posedge clk) begin
      if (start) begin
         case (offset)
            OFS_SCRATCH:  rd_data <= scratch;
            OFS_CYCLES:   rd_data <= cycles;
            OFS_TIMEOUTS: rd_data <= {16'h0000, timeout_count};
            default:      rd_data <= '0;
         endcase
      end
   end

   assign io_rsp.data   = rd_data;
   assign io_rsp.ack    = ack_q;
   assign io_rsp.decode = decode;

endmodule

//--- source/xbus_top.sv
// Top level of the xbus memory side with control, RAM bridge, SDRAM model and I/O block
module xbus_top (
   input  logic                clk,
   input  logic                reset,
   input  xbus_pkg::xbus_req_t bus_req,
   output xbus_pkg::xbus_rsp_t bus_rsp
);

   xbus_pkg::xbus_rsp_t  ram_rsp;
   xbus_pkg::xbus_rsp_t  io_rsp;
   xbus_pkg::sdram_cmd_t sdram_cmd;
   xbus_pkg::sdram_rsp_t sdram_rsp;
   logic [15:0]          timeout_count;

   // Response select and timeout
   xbus_ctrl u_xbus_ctrl (
      .clk           (clk),
      .reset         (reset),
      .bus_req       (bus_req),
      .ram_rsp       (ram_rsp),
      .io_rsp        (io_rsp),
      .bus_rsp       (bus_rsp),
      .timeout_count (timeout_count)
   );

   xbus_ram u_xbus_ram (
      .clk       (clk),
      .reset     (reset),
      .bus_req   (bus_req),
      .ram_rsp   (ram_rsp),
      .sdram_cmd (sdram_cmd),
      .sdram_rsp (sdram_rsp)
   );

   sdram_ctrl u_sdram_ctrl (
      .clk       (clk),
      .reset     (reset),
      .sdram_cmd (sdram_cmd),
      .sdram_rsp (sdram_rsp)
   );

   // Registers, including the timeout count readback
   xbus_io u_xbus_io (
      .clk           (clk),
      .reset         (reset),
      .bus_req       (bus_req),
      .timeout_count (timeout_count),
      .io_rsp        (io_rsp)
   );

endmodule

//--- bench/xbus_assertions.sv
// Concurrent protocol assertions bound into xbus_top
`include "xbus_defines.svh"

module xbus_assertions (
   input logic                 clk,
   input logic                 reset,
   input xbus_pkg::xbus_rsp_t  bus_rsp,
   input xbus_pkg::sdram_cmd_t sdram_cmd,
   input xbus_pkg::sdram_rsp_t sdram_rsp
);

   // One ack pulse per request
   ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
      bus_rsp.ack |=> !bus_rsp.ack)
      else $error("bus ack held high for two cycles");

   // Each pulse answers the held command of its own kind
   ready_done_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(sdram_rsp.ready && sdram_rsp.done) &&
      (!sdram_rsp.ready || (sdram_cmd.req && !sdram_cmd.write)) &&
      (!sdram_rsp.done || (sdram_cmd.write && !sdram_cmd.req)))
      else $error("sdram ready and done high together or not matching the command");

   // Gap addresses never reach the controller
   cmd_in_backed_range: assert property (@(posedge clk) disable iff (reset)
      (sdram_cmd.req || sdram_cmd.write) |-> (sdram_cmd.addr < 22'(`SDRAM_WORDS)))
      else $error("sdram command issued outside the backed words");

endmodule

bind xbus_top xbus_assertions u_xbus_assertions (
   .clk       (clk),
   .reset     (reset),
   .bus_rsp   (bus_rsp),
   .sdram_cmd (sdram_cmd),
   .sdram_rsp (sdram_rsp)
);

//--- bench/xbus_tb.sv
// Testbench for xbus_top with clock, reset, LFSR, directed tests, compare tasks and watchdog
`include "xbus_defines.svh"

module xbus_tb;

   localparam int RAM_AW        = $clog2(`SDRAM_WORDS);
   localparam int READ_CYCLES   = 1 + `SDRAM_READ_LAT;
   localparam int WRITE_CYCLES  = 1 + `SDRAM_WRITE_LAT;
   localparam int DIRECT_CYCLES = 1;
   localparam int ACK_LIMIT     = `XBUS_TIMEOUT + 8;
   localparam int RAM_PASSES    = 32;
   localparam int IDLE_GAP      = 5;

   // Worst case per test; setup, drop and idle add 3 cycles to each access
   localparam int SLACK     = 3;
   localparam int T1_CYCLES = READ_CYCLES + SLACK;
   localparam int T2_CYCLES = RAM_PASSES * (WRITE_CYCLES + READ_CYCLES + 2 * SLACK);
   localparam int T3_CYCLES = WRITE_CYCLES + READ_CYCLES + 2 * DIRECT_CYCLES + 4 * SLACK;
   localparam int T4_CYCLES = 5 * (DIRECT_CYCLES + SLACK) + IDLE_GAP;
   localparam int T5_CYCLES = 3 * (`XBUS_TIMEOUT + SLACK) + DIRECT_CYCLES + SLACK;
   localparam int WATCHDOG_CYCLES =
      2 + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES + 100;

   logic                clk = 1'b0;
   logic                reset;
   xbus_pkg::xbus_req_t bus_req;
   xbus_pkg::xbus_rsp_t bus_rsp;
   logic [31:0]         lfsr_state;
   int                  edge_cnt = 0;
   string               test_name;
   logic [31:0]         model [`SDRAM_WORDS];

   xbus_top u_xbus_top (
      .clk     (clk),
      .reset   (reset),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      edge_cnt <= edge_cnt + 1;
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] lfsr_take(input int nbits);
      logic [31:0] value;
      logic        lsb;
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lsb = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
         end
         value = {value[30:0], lsb};
      end
      return value;
   endfunction

   function automatic xbus_pkg::xbus_rsp_t expected_rsp(input logic [31:0] data,
                                                        input logic decode);
      xbus_pkg::xbus_rsp_t rsp;
      rsp.data   = data;
      rsp.ack    = 1'b1;
      rsp.decode = decode;
      return rsp;
   endfunction

   function automatic logic [21:0] io_addr(input int offset);
      return `XBUS_IO_BASE + 22'(offset);
   endfunction

   task automatic end_with_failure(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic compare_data(input logic [31:0] expected, input logic [31:0] actual);
      if (actual !== expected) begin
         end_with_failure($sformatf("Fail %s: expected %h actual %h",
                                    test_name, expected, actual));
      end
   endtask

   task automatic compare_rsp(input xbus_pkg::xbus_rsp_t expected,
                              input xbus_pkg::xbus_rsp_t actual);
      if (actual !== expected) begin
         end_with_failure($sformatf(
            "Fail %s: expected data %h ack %b decode %b actual data %h ack %b decode %b",
            test_name, expected.data, expected.ack, expected.decode,
            actual.data, actual.ack, actual.decode));
      end
   endtask

   task automatic compare_cycles(input int expected, input int actual);
      if (actual != expected) begin
         end_with_failure($sformatf("Fail %s: expected %0d cycles actual %0d",
                                    test_name, expected, actual));
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // Called 1 unit after a rising edge; the next edge is the first that sees req
   task automatic bus_access(input logic [21:0] addr, input logic write,
                             input logic [31:0] data, output xbus_pkg::xbus_rsp_t rsp,
                             output int cycles, output int start_edge);
      bus_req.addr  = addr;
      bus_req.data  = data;
      bus_req.write = write;
      bus_req.req   = 1'b1;
      start_edge    = edge_cnt + 1;
      cycles        = 0;
      rsp           = '0;
      @(negedge clk);
      while (bus_rsp.ack !== 1'b1 && cycles < ACK_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (bus_rsp.ack !== 1'b1) begin
         end_with_failure($sformatf("%s: no ack within %0d cycles for address %h",
                                    test_name, ACK_LIMIT, addr));
      end else begin
         rsp = bus_rsp;
         @(posedge clk);
         #1;
         bus_req.req = 1'b0;
         idle_cycles(1);
      end
   endtask

   task automatic read_after_reset();
      xbus_pkg::xbus_rsp_t rsp;
      int                  cycles;
      int                  start;
      test_name = "read_after_reset";
      bus_access(22'(lfsr_take(RAM_AW)), 1'b0, 32'h0, rsp, cycles, start);
      compare_rsp(expected_rsp(32'h0, 1'b1), rsp);
      compare_cycles(READ_CYCLES, cycles);
   endtask

   task automatic ram_write_read();
      logic [21:0]         addrs [RAM_PASSES];
      logic [31:0]         data;
      xbus_pkg::xbus_rsp_t rsp;
      int                  cycles;
      int                  start;
      test_name = "ram_write_read";
      for (int i = 0; i < RAM_PASSES; i++) begin
         addrs[i] = 22'(lfsr_take(RAM_AW));
         data = lfsr_take(32);
         model[addrs[i][RAM_AW-1:0]] = data;
         bus_access(addrs[i], 1'b1, data, rsp, cycles, start);
         compare_cycles(WRITE_CYCLES, cycles);
      end
      // Repeated addresses expect the last write
      for (int i = 0; i < RAM_PASSES; i++) begin
         bus_access(addrs[i], 1'b0, 32'h0, rsp, cycles, start);
         compare_rsp(expected_rsp(model[addrs[i][RAM_AW-1:0]], 1'b1), rsp);
         compare_cycles(READ_CYCLES, cycles);
      end
   endtask

   task automatic gap_access();
      logic [21:0]         backed;
      logic [21:0]         gap;
      logic [31:0]         data;
      xbus_pkg::xbus_rsp_t rsp;
      int                  cycles;
      int                  start;
      test_name = "gap_access";
      backed = 22'(lfsr_take(RAM_AW));
      gap    = backed + 22'(5 * `SDRAM_WORDS);
      data   = lfsr_take(32);
      model[backed[RAM_AW-1:0]] = data;
      bus_access(backed, 1'b1, data, rsp, cycles, start);
      compare_cycles(WRITE_CYCLES, cycles);
      bus_access(gap, 1'b1, ~data, rsp, cycles, start);
      compare_cycles(DIRECT_CYCLES, cycles);
      bus_access(gap, 1'b0, 32'h0, rsp, cycles, start);
      compare_rsp(expected_rsp(`XBUS_DEAD_DATA, 1'b1), rsp);
      compare_cycles(DIRECT_CYCLES, cycles);
      // Same low bits must still hold the backed word
      bus_access(backed, 1'b0, 32'h0, rsp, cycles, start);
      compare_rsp(expected_rsp(model[backed[RAM_AW-1:0]], 1'b1), rsp);
      compare_cycles(READ_CYCLES, cycles);
   endtask

   task automatic io_registers();
      logic [31:0]         data;
      logic [31:0]         first;
      xbus_pkg::xbus_rsp_t rsp;
      int                  cycles;
      int                  start_a;
      int                  start_b;
      test_name = "io_registers";
      data = lfsr_take(32);
      bus_access(io_addr(0), 1'b1, data, rsp, cycles, start_a);
      compare_cycles(DIRECT_CYCLES, cycles);
      bus_access(io_addr(0), 1'b0, 32'h0, rsp, cycles, start_a);
      compare_rsp(expected_rsp(data, 1'b1), rsp);
      compare_cycles(DIRECT_CYCLES, cycles);
      bus_access(io_addr(1), 1'b0, 32'h0, rsp, cycles, start_a);
      compare_cycles(DIRECT_CYCLES, cycles);
      first = rsp.data;
      idle_cycles(IDLE_GAP);
      bus_access(io_addr(1), 1'b0, 32'h0, rsp, cycles, start_b);
      compare_cycles(DIRECT_CYCLES, cycles);
      compare_data(32'(start_b - start_a), rsp.data - first);
      // Unused offset
      bus_access(io_addr(7), 1'b0, 32'h0, rsp, cycles, start_a);
      compare_rsp(expected_rsp(32'h0, 1'b1), rsp);
      compare_cycles(DIRECT_CYCLES, cycles);
   endtask

   task automatic unmapped_timeout();
      xbus_pkg::xbus_rsp_t rsp;
      int                  cycles;
      int                  start;
      test_name = "unmapped_timeout";
      for (int i = 0; i < 3; i++) begin
         bus_access(22'o14000000, 1'b0, 32'h0, rsp, cycles, start);
         compare_rsp(expected_rsp(`XBUS_DEAD_DATA, 1'b0), rsp);
         compare_cycles(`XBUS_TIMEOUT, cycles);
      end
      bus_access(io_addr(2), 1'b0, 32'h0, rsp, cycles, start);
      compare_rsp(expected_rsp(32'd3, 1'b1), rsp);
      compare_cycles(DIRECT_CYCLES, cycles);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      end_with_failure($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
   end

   initial begin
      lfsr_state = 32'hfd05;
      test_name  = "reset";
      reset      = 1'b1;
      bus_req    = '0;
      for (int i = 0; i < `SDRAM_WORDS; i++) begin
         model[i] = '0;
      end
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      read_after_reset();
      ram_write_read();
      gap_access();
      io_registers();
      unmapped_timeout();
      $display("TEST PASSED");
      $finish;
   end

endmodule

//--- tb.f
+incdir+source
source/xbus_pkg.sv
source/xbus_ctrl.sv
source/xbus_ram.sv
source/sdram_ctrl.sv
source/xbus_io.sv
source/xbus_top.sv
bench/xbus_assertions.sv
bench/xbus_tb.sv

//--- run.sh
#!/bin/sh
# Build the xbus testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module xbus_tb -f tb.f -o xbus_sim &&
./obj_dir/xbus_sim | tee /dev/stderr | grep -q "^TEST PASSED$" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
